// ==== gb_apu.f ====
+incdir+rtl
rtl/apu_pkg.sv
rtl/frame_sequencer.sv
rtl/apu_regs.sv
rtl/length_counter.sv
rtl/volume_envelope.sv
rtl/frequency_sweep.sv
rtl/square_channel.sv
rtl/apu_mixer.sv
rtl/gb_apu.sv
testbench/gb_apu_asserts.sv
testbench/gb_apu_tb.sv

// ==== testbench/gb_apu_tb.sv ====
////////////////////////////////////////
// Sound unit testbench
////////////////////////////////////////
`timescale 1ns/1ps
`include "apu_consts.svh"

module gb_apu_tb import apu_pkg::*; ();
    localparam int BUS_TIMEOUT  = 16;
    localparam int STEP_TIMEOUT = 4 * `APU_FRAME_DIV;
    localparam int PEAK_WINDOW  = 40;  // Longer than one 32-cycle duty period.

    logic                      system_clock;
    logic                      rst;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`APU_WB_ADDR_W-1:0] wb_adr;
    reg_byte_t                 wb_dat_w;
    reg_byte_t                 wb_dat_r;
    logic                      wb_ack;
    level_t                    left;
    level_t                    right;

    logic [31:0] lcg_state;
    int          cycle_count;
    int          step_count;
    int          checks;
    int          value_errors;
    int          timeouts;

    gb_apu gb_apu_inst (
        .system_clock(system_clock), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .left(left), .right(right)
    );

    always #50 system_clock = ~system_clock;

    // Counts frame steps at the edge where the channels act on them.
    always @(posedge system_clock) begin
        if (rst) begin
            cycle_count <= 0;
            step_count  <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            if (cycle_count > 0 && cycle_count % `APU_FRAME_DIV == 0)
                step_count <= step_count + 1;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;  // Low bits of an LCG repeat quickly.
    endfunction

    // Bits 6 to 4 of NR52 always read as ones.
    function automatic reg_byte_t nr52_value(logic on, logic act1, logic act2);
        return {on, 5'b00000, act2, act1} | 8'h70;
    endfunction

    function automatic int sweep_result(int shadow, logic negate, int shift);
        return negate ? shadow - (shadow >> shift) : shadow + (shadow >> shift);
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            value_errors++;
            $display("ERR %0t: %s got %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [`APU_WB_ADDR_W-1:0] adr,
                             input reg_byte_t data, output reg_byte_t rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        @(negedge system_clock);
        while (!wb_ack && waited < BUS_TIMEOUT) begin
            @(negedge system_clock);
            waited++;
        end
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            timeouts++;
            $display("Timeout: no bus ack for address %0h", adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge system_clock);  // Strobe stays low for a cycle.
    endtask

    task automatic reg_write(input logic [`APU_WB_ADDR_W-1:0] adr, input reg_byte_t data);
        reg_byte_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic reg_read(input logic [`APU_WB_ADDR_W-1:0] adr, output reg_byte_t data);
        bus_cycle(1'b0, adr, 8'h00, data);
    endtask

    task automatic check_status(input logic act1, input logic act2);
        reg_byte_t value;
        reg_read(`APU_ADDR_NR52, value);
        check_value("NR52", value, nr52_value(1'b1, act1, act2));
    endtask

    // Takes the next frame step after seen, even one that came during a bus cycle.
    task automatic wait_step(inout int seen, output int idx);
        int waited;
        waited = 0;
        while (step_count <= seen && waited < STEP_TIMEOUT) begin
            @(negedge system_clock);
            waited++;
        end
        if (step_count <= seen) begin
            timeouts++;
            $display("Timeout: frame step %0d never arrived", seen);
        end
        idx  = seen % 8;
        seen = seen + 1;
        repeat (2) @(negedge system_clock);
    endtask

    task automatic measure_peaks(output int peak_l, output int peak_r);
        peak_l = 0;
        peak_r = 0;
        repeat (PEAK_WINDOW) begin
            @(negedge system_clock);
            if (left > peak_l)
                peak_l = left;
            if (right > peak_r)
                peak_r = right;
        end
    endtask

    // 50 % duty at frequency 2044, four cycles per duty step.
    task automatic load_tone(input logic second, input reg_byte_t envelope);
        reg_write(second ? `APU_ADDR_NR21 : `APU_ADDR_NR11, 8'h80);
        reg_write(second ? `APU_ADDR_NR22 : `APU_ADDR_NR12, envelope);
        reg_write(second ? `APU_ADDR_NR23 : `APU_ADDR_NR13, 8'hfc);
    endtask

    task automatic start_pair(input int v1, input int v2, input reg_byte_t pan,
                              input reg_byte_t master);
        reg_write(`APU_ADDR_NR50, master);
        reg_write(`APU_ADDR_NR51, pan);
        reg_write(`APU_ADDR_NR10, 8'h00);
        load_tone(1'b0, reg_byte_t'(v1 << 4));
        load_tone(1'b1, reg_byte_t'(v2 << 4));
        reg_write(`APU_ADDR_NR14, 8'h87);  // Triggers two cycles apart, so the highs overlap.
        reg_write(`APU_ADDR_NR24, 8'h87);
    endtask

    task automatic readback_registers();
        logic [`APU_WB_ADDR_W-1:0] addrs [12];
        reg_byte_t                 masks [12];
        reg_byte_t                 written [12];
        reg_byte_t                 value;
        addrs = '{`APU_ADDR_NR10, `APU_ADDR_NR11, `APU_ADDR_NR12, `APU_ADDR_NR13,
                  `APU_ADDR_NR14, `APU_ADDR_NR21, `APU_ADDR_NR22, `APU_ADDR_NR23,
                  `APU_ADDR_NR24, `APU_ADDR_NR50, `APU_ADDR_NR51, `APU_ADDR_NR52};
        masks = '{8'h80, 8'h3f, 8'h00, 8'hff, 8'hbf, 8'h3f,
                  8'h00, 8'hff, 8'hbf, 8'h00, 8'h00, 8'h70};
        for (int i = 0; i < 12; i++) begin
            written[i] = reg_byte_t'(next_random());
            if (addrs[i] == `APU_ADDR_NR14 || addrs[i] == `APU_ADDR_NR24)
                written[i][7] = 1'b0;  // No trigger, so both channels stay off.
            if (addrs[i] == `APU_ADDR_NR52)
                written[i] = 8'h80;
            reg_write(addrs[i], written[i]);
        end
        for (int i = 0; i < 12; i++) begin
            reg_read(addrs[i], value);
            check_value($sformatf("wb_dat_r at %0h", addrs[i]), value, written[i] | masks[i]);
        end
    endtask

    task automatic length_expiry(input logic second);
        reg_byte_t load;
        int        remaining;
        int        seen;
        int        idx;
        int        guard;
        load = reg_byte_t'(next_random()) & 8'h3f;
        reg_write(`APU_ADDR_NR10, 8'h00);
        reg_write(second ? `APU_ADDR_NR21 : `APU_ADDR_NR11, 8'h80 | load);
        reg_write(second ? `APU_ADDR_NR22 : `APU_ADDR_NR12, 8'hf0);
        reg_write(second ? `APU_ADDR_NR23 : `APU_ADDR_NR13, reg_byte_t'(next_random()));
        reg_write(second ? `APU_ADDR_NR24 : `APU_ADDR_NR14,
                  reg_byte_t'(8'hc0 | (next_random() & 7)));
        seen      = step_count;
        remaining = 64 - int'(load);
        guard     = 0;
        check_status(!second, second);
        while (remaining > 0 && guard < 160) begin
            wait_step(seen, idx);
            if (idx % 2 == 0)
                remaining--;
            check_status(!second && remaining > 0, second && remaining > 0);
            guard++;
        end
    endtask

    task automatic envelope_levels(input logic dir);
        volume_t    init;
        logic [2:0] period;
        int         count;
        int         volume;
        int         timer;
        int         done;
        int         seen;
        int         idx;
        int         peak_l;
        int         peak_r;
        init   = volume_t'(next_random());
        period = 3'(1 + next_random() % 3);
        count  = 1 + next_random() % 4;
        reg_write(`APU_ADDR_NR50, 8'h77);
        reg_write(`APU_ADDR_NR51, 8'h11);
        reg_write(`APU_ADDR_NR10, 8'h00);
        load_tone(1'b0, {init, dir, period});
        reg_write(`APU_ADDR_NR14, 8'h87);
        seen   = step_count;
        volume = init;
        timer  = period;
        done   = 0;
        while (done < count) begin
            wait_step(seen, idx);
            if (idx == 7) begin
                done++;
                if (timer <= 1) begin
                    timer = period;
                    if (dir && volume < 15)
                        volume++;
                    else if (!dir && volume > 0)
                        volume--;
                end else begin
                    timer--;
                end
            end
        end
        measure_peaks(peak_l, peak_r);
        check_value("left peak", peak_l, 8 * volume);
    endtask

    task automatic sweep_overflow(input logic negate);
        int         freq;
        int         shift;
        logic [2:0] period;
        int         shadow;
        int         timer;
        logic       overflow;
        int         seen;
        int         idx;
        freq   = negate ? int'(next_random() & 32'h7ff) : 1536 + next_random() % 512;
        shift  = 1 + next_random() % (negate ? 3 : 2);
        period = 3'(1 + next_random() % 2);
        reg_write(`APU_ADDR_NR10, {1'b0, period, negate, 3'(shift)});
        reg_write(`APU_ADDR_NR11, 8'h80);
        reg_write(`APU_ADDR_NR12, 8'hf0);
        reg_write(`APU_ADDR_NR13, reg_byte_t'(freq & 255));
        reg_write(`APU_ADDR_NR14, reg_byte_t'(8'h80 | (freq >> 8)));
        seen     = step_count;
        shadow   = freq;
        timer    = period;
        overflow = sweep_result(freq, negate, shift) > 2047;  // Checked at trigger too.
        repeat (1) @(negedge system_clock);
        check_status(!overflow, 1'b0);
        for (int n = 0; n < 32; n++) begin
            wait_step(seen, idx);
            if (idx == 2 || idx == 6) begin
                if (timer <= 1) begin
                    timer = period;
                    if (sweep_result(shadow, negate, shift) > 2047)
                        overflow = 1'b1;
                    else
                        shadow = sweep_result(shadow, negate, shift);
                end else begin
                    timer--;
                end
            end
            check_status(!overflow, 1'b0);
        end
    endtask

    task automatic pan_and_volume();
        int        v1;
        int        v2;
        reg_byte_t pan;
        reg_byte_t master;
        int        peak_l;
        int        peak_r;
        for (int n = 0; n < 4; n++) begin
            v1     = next_random() % 16;
            v2     = next_random() % 16;
            pan    = reg_byte_t'(next_random());
            master = reg_byte_t'(next_random());
            start_pair(v1, v2, pan, master);
            measure_peaks(peak_l, peak_r);
            check_value("left peak", peak_l,
                        ((pan[4] ? v1 : 0) + (pan[5] ? v2 : 0)) * (master[6:4] + 1));
            check_value("right peak", peak_r,
                        ((pan[0] ? v1 : 0) + (pan[1] ? v2 : 0)) * (master[2:0] + 1));
        end
    endtask

    task automatic power_down();
        int        peak_l;
        int        peak_r;
        int        waited;
        reg_byte_t value;
        start_pair(15, 15, 8'h33, 8'h77);
        measure_peaks(peak_l, peak_r);
        check_value("left peak", peak_l, 240);
        reg_write(`APU_ADDR_NR52, 8'h00);
        waited = 0;
        while ((left != 0 || right != 0) && waited < 2) begin
            @(negedge system_clock);
            waited++;
        end
        check_value("left", left, 0);
        check_value("right", right, 0);
        reg_read(`APU_ADDR_NR52, value);
        check_value("NR52", value, nr52_value(1'b0, 1'b0, 1'b0));
    endtask

    initial begin
        system_clock = 1'b0;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        lcg_state    = 32'hb458c3d0;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        repeat (4) @(negedge system_clock);
        rst = 1'b0;
        reg_write(`APU_ADDR_NR52, 8'h80);
        readback_registers();
        length_expiry(1'b0);
        length_expiry(1'b1);
        envelope_levels(1'b1);
        envelope_levels(1'b0);
        sweep_overflow(1'b0);
        sweep_overflow(1'b1);
        pan_and_volume();
        power_down();
        $display("Checks %0d, value errors %0d, timeouts %0d, assertion errors %0d", checks,
                 value_errors, timeouts, gb_apu_inst.asserts_inst.assert_errors);
        if (value_errors == 0 && timeouts == 0 && gb_apu_inst.asserts_inst.assert_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== testbench/gb_apu_asserts.sv ====
////////////////////////////////////////
// Sound unit assertions
////////////////////////////////////////
`timescale 1ns/1ps

module gb_apu_asserts import apu_pkg::*; (
    input logic        system_clock,
    input logic        rst,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input frame_step_t frame_step,
    input level_t      left,
    input level_t      right
);
    localparam int MAX_LEVEL = 2 * 15 * 8;

    int assert_errors = 0;

    ack_one_cycle: assert property (@(posedge system_clock) disable iff (rst)
        wb_ack |=> !wb_ack)
        else begin
            assert_errors++;
            $error("Bus ack held for more than one cycle");
        end

    ack_after_strobe: assert property (@(posedge system_clock) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            assert_errors++;
            $error("Bus ack without a preceding strobe");
        end

    // Length and sweep share steps 2 and 6; the envelope step stands alone.
    env_step_alone: assert property (@(posedge system_clock) disable iff (rst)
        frame_step.env_step |-> !(frame_step.length_step || frame_step.sweep_step))
        else begin
            assert_errors++;
            $error("Envelope step overlaps another frame strobe");
        end

    sweep_with_length: assert property (@(posedge system_clock) disable iff (rst)
        frame_step.sweep_step |-> frame_step.length_step)
        else begin
            assert_errors++;
            $error("Sweep step outside a length step");
        end

    output_range: assert property (@(posedge system_clock) disable iff (rst)
        (left <= MAX_LEVEL) && (right <= MAX_LEVEL))
        else begin
            assert_errors++;
            $error("Mixer output above full scale");
        end

endmodule

bind gb_apu gb_apu_asserts asserts_inst (
    .system_clock(system_clock),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .frame_step  (frame_step),
    .left        (left),
    .right       (right)
);

// ==== rtl/gb_apu.sv ====
////////////////////////////////////////
// Sound unit top
////////////////////////////////////////
`timescale 1ns/1ps
`include "apu_consts.svh"

module gb_apu import apu_pkg::*; (
    input  logic                      system_clock,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`APU_WB_ADDR_W-1:0] wb_adr,
    input  reg_byte_t                 wb_dat_w,
    output reg_byte_t                 wb_dat_r,
    output logic                      wb_ack,
    output level_t                    left,
    output level_t                    right
);
    sweep_cfg_t  sweep_cfg;
    tone_cfg_t   tone1, tone2;
    logic        trigger1, trigger2;
    logic        master_on;
    logic        active1, active2;
    logic [2:0]  vol_left, vol_right;
    reg_byte_t   pan;
    volume_t     level1, level2;
    frame_step_t frame_step;

    apu_regs regs_inst (
        .system_clock(system_clock), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .active1(active1), .active2(active2),
        .sweep_cfg(sweep_cfg), .tone1(tone1), .tone2(tone2),
        .trigger1(trigger1), .trigger2(trigger2), .master_on(master_on),
        .vol_left(vol_left), .vol_right(vol_right), .pan(pan)
    );

    frame_sequencer sequencer_inst (
        .system_clock(system_clock), .rst(rst), .frame_step(frame_step)
    );

    square_channel #(.HAS_SWEEP(1'b1)) channel1_inst (
        .system_clock(system_clock), .rst(rst), .tone(tone1), .sweep_cfg(sweep_cfg),
        .trigger(trigger1), .master_on(master_on), .step(frame_step),
        .active(active1), .level(level1)
    );

    square_channel #(.HAS_SWEEP(1'b0)) channel2_inst (
        .system_clock(system_clock), .rst(rst), .tone(tone2), .sweep_cfg(sweep_cfg),
        .trigger(trigger2), .master_on(master_on), .step(frame_step),
        .active(active2), .level(level2)
    );

    apu_mixer mixer_inst (
        .system_clock(system_clock), .rst(rst), .level1(level1), .level2(level2),
        .pan(pan), .vol_left(vol_left), .vol_right(vol_right),
        .left(left), .right(right)
    );

endmodule

// ==== rtl/apu_mixer.sv ====
////////////////////////////////////////
// Stereo mixer
////////////////////////////////////////
`timescale 1ns/1ps

module apu_mixer import apu_pkg::*; (
    input  logic       system_clock,
    input  logic       rst,
    input  volume_t    level1,
    input  volume_t    level2,
    input  reg_byte_t  pan,
    input  logic [2:0] vol_left,
    input  logic [2:0] vol_right,
    output level_t     left,
    output level_t     right
);
    logic [4:0] sum_left;
    logic [4:0] sum_right;
    logic [3:0] scale_left;
    logic [3:0] scale_right;

    // NR51 bits 4 and 5 feed the left side, bits 0 and 1 the right.
    assign sum_left  = (pan[4] ? {1'b0, level1} : 5'd0) + (pan[5] ? {1'b0, level2} : 5'd0);
    assign sum_right = (pan[0] ? {1'b0, level1} : 5'd0) + (pan[1] ? {1'b0, level2} : 5'd0);

    assign scale_left  = {1'b0, vol_left} + 4'd1;
    assign scale_right = {1'b0, vol_right} + 4'd1;

    always_ff @(posedge system_clock) begin
        if (rst) begin
            left  <= '0;
            right <= '0;
        end else begin
            left  <= level_t'(sum_left) * level_t'(scale_left);  // At most 30 times 8.
            right <= level_t'(sum_right) * level_t'(scale_right);
        end
    end

endmodule

// ==== rtl/square_channel.sv ====
////////////////////////////////////////
// Square tone channel
////////////////////////////////////////
`timescale 1ns/1ps

module square_channel import apu_pkg::*; #(
    parameter bit HAS_SWEEP = 1'b0
) (
    input  logic        system_clock,
    input  logic        rst,
    input  tone_cfg_t   tone,
    input  sweep_cfg_t  sweep_cfg,
    input  logic        trigger,
    input  logic        master_on,
    input  frame_step_t step,
    output logic        active,
    output volume_t     level
);
    // Patterns for 12.5, 25, 50 and 75 percent duty.
    localparam logic [7:0] DUTY_WAVE [4] = '{8'b0000_0001, 8'b1000_0001,
                                            8'b1000_0111, 8'b0111_1110};

    logic [11:0] timer;
    logic [2:0]  duty_pos;
    freq_t       cur_freq;
    logic        expired;
    logic        overflow;
    volume_t     env_volume;

    length_counter length_inst (
        .system_clock (system_clock),
        .rst          (rst),
        .trigger      (trigger),
        .load         (tone.length),
        .length_enable(tone.length_en),
        .length_step  (step.length_step),
        .expired      (expired)
    );

    volume_envelope envelope_inst (
        .system_clock(system_clock),
        .rst         (rst),
        .trigger     (trigger),
        .init_volume (tone.init_vol),
        .direction   (tone.env_dir),
        .period      (tone.env_period),
        .env_step    (step.env_step),
        .volume      (env_volume)
    );

    generate
        if (HAS_SWEEP) begin : g_sweep
            frequency_sweep sweep_inst (
                .system_clock(system_clock),
                .rst         (rst),
                .trigger     (trigger),
                .cfg         (sweep_cfg),
                .freq_init   (tone.freq),
                .sweep_step  (step.sweep_step),
                .freq        (cur_freq),
                .overflow    (overflow)
            );
        end else begin : g_fixed
            assign cur_freq = tone.freq;
            assign overflow = 1'b0;
        end
    endgenerate

    // The shadow frequency loads on the trigger edge, so the first period uses the register.
    always_ff @(posedge system_clock) begin
        if (rst) begin
            timer    <= '0;
            duty_pos <= '0;
        end else if (trigger) begin
            timer    <= 12'd2048 - {1'b0, tone.freq};
            duty_pos <= '0;
        end else if (timer <= 12'd1) begin
            timer    <= 12'd2048 - {1'b0, cur_freq};
            duty_pos <= duty_pos + 1'b1;
        end else begin
            timer <= timer - 1'b1;
        end
    end

    always_ff @(posedge system_clock) begin
        if (rst || !master_on)
            active <= 1'b0;
        else if (trigger)
            active <= 1'b1;
        else if (expired || overflow)
            active <= 1'b0;
    end

    assign level = (active && DUTY_WAVE[tone.duty][duty_pos]) ? env_volume : '0;

endmodule

// ==== rtl/frequency_sweep.sv ====
////////////////////////////////////////
// Frequency sweep
////////////////////////////////////////
`timescale 1ns/1ps

module frequency_sweep import apu_pkg::*; (
    input  logic       system_clock,
    input  logic       rst,
    input  logic       trigger,
    input  sweep_cfg_t cfg,
    input  freq_t      freq_init,
    input  logic       sweep_step,
    output freq_t      freq,
    output logic       overflow
);
    freq_t       shadow;
    logic [2:0]  timer;
    logic [11:0] next_freq;
    logic [11:0] trig_freq;

    // Bit 11 of the result flags a frequency above 2047.
    function automatic logic [11:0] sweep_calc(freq_t base, sweep_cfg_t c);
        logic [11:0] delta;
        delta = {1'b0, base} >> c.shift;
        return c.negate ? {1'b0, base} - delta : {1'b0, base} + delta;
    endfunction

    assign next_freq = sweep_calc(shadow, cfg);
    assign trig_freq = sweep_calc(freq_init, cfg);
    assign freq      = shadow;

    always_ff @(posedge system_clock) begin
        if (rst) begin
            shadow   <= '0;
            timer    <= '0;
            overflow <= 1'b0;
        end else if (trigger) begin
            shadow   <= freq_init;
            timer    <= cfg.period;
            overflow <= (cfg.shift != 3'd0) && trig_freq[11];
        end else if (sweep_step && cfg.period != 3'd0) begin
            if (timer <= 3'd1) begin
                timer <= cfg.period;
                if (next_freq[11])
                    overflow <= 1'b1;
                else if (cfg.shift != 3'd0)
                    shadow <= next_freq[10:0];
            end else begin
                timer <= timer - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/volume_envelope.sv ====
////////////////////////////////////////
// Volume envelope
////////////////////////////////////////
`timescale 1ns/1ps

module volume_envelope import apu_pkg::*; (
    input  logic       system_clock,
    input  logic       rst,
    input  logic       trigger,
    input  volume_t    init_volume,
    input  logic       direction,
    input  logic [2:0] period,
    input  logic       env_step,
    output volume_t    volume
);
    logic [2:0] timer;
    logic       at_bound;

    assign at_bound = direction ? (volume == 4'hf) : (volume == 4'h0);

    always_ff @(posedge system_clock) begin
        if (rst) begin
            volume <= '0;
            timer  <= '0;
        end else if (trigger) begin
            volume <= init_volume;
            timer  <= period;
        end else if (env_step && period != 3'd0) begin
            if (timer <= 3'd1) begin
                timer <= period;
                if (!at_bound)
                    volume <= direction ? volume + 1'b1 : volume - 1'b1;
            end else begin
                timer <= timer - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/length_counter.sv ====
////////////////////////////////////////
// Length counter
////////////////////////////////////////
`timescale 1ns/1ps

module length_counter import apu_pkg::*; (
    input  logic    system_clock,
    input  logic    rst,
    input  logic    trigger,
    input  length_t load,
    input  logic    length_enable,
    input  logic    length_step,
    output logic    expired
);
    logic [6:0] count;  // Holds 0 to 64.

    always_ff @(posedge system_clock) begin
        if (rst) begin
            count   <= '0;
            expired <= 1'b0;
        end else if (trigger) begin
            count   <= 7'd64 - {1'b0, load};  // A load of 0 gives the full 64.
            expired <= 1'b0;
        end else if (length_step && length_enable && count != '0) begin
            count <= count - 1'b1;
            if (count == 7'd1)
                expired <= 1'b1;
        end
    end

endmodule

// ==== rtl/apu_regs.sv ====
////////////////////////////////////////
// Register bank on Wishbone
////////////////////////////////////////
`timescale 1ns/1ps
`include "apu_consts.svh"

module apu_regs import apu_pkg::*; (
    input  logic                      system_clock,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`APU_WB_ADDR_W-1:0] wb_adr,
    input  reg_byte_t                 wb_dat_w,
    output reg_byte_t                 wb_dat_r,
    output logic                      wb_ack,
    input  logic                      active1,
    input  logic                      active2,
    output sweep_cfg_t                sweep_cfg,
    output tone_cfg_t                 tone1,
    output tone_cfg_t                 tone2,
    output logic                      trigger1,
    output logic                      trigger2,
    output logic                      master_on,
    output logic [2:0]                vol_left,
    output logic [2:0]                vol_right,
    output reg_byte_t                 pan
);
    wb_state_t state;
    reg_byte_t nr10, nr11, nr12, nr13, nr14;
    reg_byte_t nr21, nr22, nr23, nr24;
    reg_byte_t nr50, nr51;
    reg_byte_t rd_value;
    logic      bus_req;
    logic      bus_write;
    logic      power_off_write;

    function automatic tone_cfg_t make_tone(reg_byte_t len_reg, reg_byte_t env_reg,
                                            reg_byte_t lo_reg, reg_byte_t hi_reg);
        tone_cfg_t cfg;
        cfg.duty       = len_reg[7:6];
        cfg.length     = len_reg[5:0];
        cfg.init_vol   = env_reg[7:4];
        cfg.env_dir    = env_reg[3];
        cfg.env_period = env_reg[2:0];
        cfg.freq       = {hi_reg[2:0], lo_reg};
        cfg.length_en  = hi_reg[6];
        return cfg;
    endfunction

    assign bus_req         = wb_cyc && wb_stb && (state == WB_IDLE);
    assign bus_write       = bus_req && wb_we;
    assign power_off_write = bus_write && (wb_adr == `APU_ADDR_NR52) && !wb_dat_w[7];
    assign wb_ack          = (state == WB_ACK);

    assign sweep_cfg = sweep_cfg_t'(nr10[6:0]);
    assign tone1     = make_tone(nr11, nr12, nr13, nr14);
    assign tone2     = make_tone(nr21, nr22, nr23, nr24);
    assign vol_left  = nr50[6:4];
    assign vol_right = nr50[2:0];
    assign pan       = nr51;

    // Write-only and unused bits read back as ones.
    always_comb begin
        case (wb_adr)
            `APU_ADDR_NR10: rd_value = nr10 | 8'h80;
            `APU_ADDR_NR11: rd_value = nr11 | 8'h3f;
            `APU_ADDR_NR12: rd_value = nr12;
            `APU_ADDR_NR13: rd_value = 8'hff;
            `APU_ADDR_NR14: rd_value = nr14 | 8'hbf;
            `APU_ADDR_NR21: rd_value = nr21 | 8'h3f;
            `APU_ADDR_NR22: rd_value = nr22;
            `APU_ADDR_NR23: rd_value = 8'hff;
            `APU_ADDR_NR24: rd_value = nr24 | 8'hbf;
            `APU_ADDR_NR50: rd_value = nr50;
            `APU_ADDR_NR51: rd_value = nr51;
            `APU_ADDR_NR52: rd_value = {master_on, 3'b111, 2'b00, active2, active1};
            default:        rd_value = 8'hff;
        endcase
    end

    always_ff @(posedge system_clock) begin
        if (rst) begin
            state     <= WB_IDLE;
            master_on <= 1'b0;
            trigger1  <= 1'b0;
            trigger2  <= 1'b0;
        end else begin
            state    <= bus_req ? WB_ACK : WB_IDLE;  // Ack lasts one cycle.
            trigger1 <= bus_write && (wb_adr == `APU_ADDR_NR14) && wb_dat_w[7];
            trigger2 <= bus_write && (wb_adr == `APU_ADDR_NR24) && wb_dat_w[7];
            if (bus_write && wb_adr == `APU_ADDR_NR52)
                master_on <= wb_dat_w[7];
        end
    end

    always_ff @(posedge system_clock) begin
        if (bus_req)
            wb_dat_r <= rd_value;
    end

    // Powering down wipes every channel and control register.
    always_ff @(posedge system_clock) begin
        if (rst || power_off_write) begin
            nr10 <= '0;
            nr11 <= '0;
            nr12 <= '0;
            nr13 <= '0;
            nr14 <= '0;
            nr21 <= '0;
            nr22 <= '0;
            nr23 <= '0;
            nr24 <= '0;
            nr50 <= '0;
            nr51 <= '0;
        end else if (bus_write) begin
            case (wb_adr)
                `APU_ADDR_NR10: nr10 <= wb_dat_w;
                `APU_ADDR_NR11: nr11 <= wb_dat_w;
                `APU_ADDR_NR12: nr12 <= wb_dat_w;
                `APU_ADDR_NR13: nr13 <= wb_dat_w;
                `APU_ADDR_NR14: nr14 <= wb_dat_w;
                `APU_ADDR_NR21: nr21 <= wb_dat_w;
                `APU_ADDR_NR22: nr22 <= wb_dat_w;
                `APU_ADDR_NR23: nr23 <= wb_dat_w;
                `APU_ADDR_NR24: nr24 <= wb_dat_w;
                `APU_ADDR_NR50: nr50 <= wb_dat_w;
                `APU_ADDR_NR51: nr51 <= wb_dat_w;
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/frame_sequencer.sv ====
////////////////////////////////////////
// Frame sequencer
////////////////////////////////////////
`timescale 1ns/1ps
`include "apu_consts.svh"

module frame_sequencer import apu_pkg::*; (
    input  logic        system_clock,
    input  logic        rst,
    output frame_step_t frame_step
);
    localparam int DIV_W = $clog2(`APU_FRAME_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       step_idx;
    logic             step_tick;

    assign step_tick = (div_cnt == DIV_W'(`APU_FRAME_DIV - 1));

    always_ff @(posedge system_clock) begin
        if (rst) begin
            div_cnt    <= '0;
            step_idx   <= '0;
            frame_step <= '0;
        end else begin
            div_cnt    <= step_tick ? '0 : div_cnt + 1'b1;
            frame_step <= '0;
            if (step_tick) begin
                step_idx               <= step_idx + 1'b1;
                frame_step.length_step <= ~step_idx[0];              // Even steps.
                frame_step.sweep_step  <= (step_idx[1:0] == 2'b10);  // Steps 2 and 6.
                frame_step.env_step    <= (step_idx == 3'd7);
            end
        end
    end

endmodule

// ==== rtl/apu_pkg.sv ====
////////////////////////////////////////
// Sound unit types
////////////////////////////////////////
package apu_pkg;

    typedef logic [7:0]  reg_byte_t;
    typedef logic [10:0] freq_t;
    typedef logic [3:0]  volume_t;
    typedef logic [5:0]  length_t;
    typedef logic [7:0]  level_t;  // Two channels at 15 times a scale of 8 reach 240.

    typedef struct packed {
        logic [2:0] period;
        logic       negate;
        logic [2:0] shift;
    } sweep_cfg_t;

    typedef struct packed {
        logic [1:0] duty;
        length_t    length;
        volume_t    init_vol;
        logic       env_dir;     // 1 counts up.
        logic [2:0] env_period;
        freq_t      freq;
        logic       length_en;
    } tone_cfg_t;

    typedef struct packed {
        logic length_step;
        logic sweep_step;
        logic env_step;
    } frame_step_t;

    typedef enum logic {WB_IDLE, WB_ACK} wb_state_t;

endpackage

// ==== rtl/apu_consts.svh ====
////////////////////////////////////////
// Sound unit constants
////////////////////////////////////////
`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

`define APU_FRAME_DIV 64  // Cycles per 512 Hz step, short for simulation.
`define APU_WB_ADDR_W 5

// Word offsets from the first sound register.
`define APU_ADDR_NR10 5'h00
`define APU_ADDR_NR11 5'h01
`define APU_ADDR_NR12 5'h02
`define APU_ADDR_NR13 5'h03
`define APU_ADDR_NR14 5'h04
`define APU_ADDR_NR21 5'h06
`define APU_ADDR_NR22 5'h07
`define APU_ADDR_NR23 5'h08
`define APU_ADDR_NR24 5'h09
`define APU_ADDR_NR50 5'h14
`define APU_ADDR_NR51 5'h15
`define APU_ADDR_NR52 5'h16

`endif
